//--- source/msx_layout_pkg.sv
`default_nettype none

package msx_layout_pkg;

   localparam int MAX_CONFIG    = 8;
   localparam int CONFIG_IDX_W  = $clog2(MAX_CONFIG);
   localparam int MAX_MEM_BLOCK = 16;
   localparam int BLOCK_ID_W    = $clog2(MAX_MEM_BLOCK);
   localparam int PAGE_BYTES    = 16;                  // Shortened page for simulation
   localparam int BYTE_CNT_W    = 8 + $clog2(PAGE_BYTES); // block_count * PAGE_BYTES
   localparam int SDRAM_ADDR_W  = 25;
   localparam int DDR3_ADDR_W   = 28;
   localparam int FIFO_DEPTH    = 8;
   localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);

   localparam logic [7:0] FILL_BYTE = 8'hFF;           // Blank RAM content

   typedef enum logic [1:0] {
      CONFIG_NONE,
      CONFIG_RAM,
      CONFIG_BIOS,
      CONFIG_FDC
   } config_typ_e;

   typedef enum logic [1:0] {
      SLOT_TYP_EMPTY,
      SLOT_TYP_ROM,
      SLOT_TYP_RAM,
      SLOT_TYP_MAPPER
   } slot_typ_e;

   typedef enum logic [1:0] {
      BLOCK_TYP_RAM,
      BLOCK_TYP_ROM,
      BLOCK_TYP_FDC
   } block_typ_e;

   typedef struct packed {
      config_typ_e              typ;
      logic [1:0]               slot;
      logic [1:0]               sub_slot;
      logic [1:0]               start_block;          // First page
      logic [BLOCK_ID_W-1:0]    block_id;
      logic [7:0]               block_count;          // Length in pages
      logic                     slot_internal_mapper;
      logic [DDR3_ADDR_W-1:0]   store_address;
   } msx_config_t;

   typedef struct packed {
      logic [BLOCK_ID_W-1:0]    block_id;
      logic [1:0]               offset;               // Page index inside the block
      logic                     init;
   } page_entry_t;

   typedef struct packed {
      slot_typ_e                typ;
      slot_typ_e [3:0]          sub_typ;
      page_entry_t [3:0][3:0]   page;                 // [subslot][page]
   } slot_t;

   typedef struct packed {
      block_typ_e               typ;
      logic [7:0]               block_count;
      logic [SDRAM_ADDR_W-1:0]  mem_offset;
   } block_t;

endpackage

`default_nettype wire

//--- source/copy_job_if.sv
`timescale 1ns/1ps
`default_nettype none

interface copy_job_if;

   logic                                     start;      // One-cycle job strobe
   logic                                     restart;    // New walk, rewind SDRAM address
   logic [msx_layout_pkg::DDR3_ADDR_W-1:0]   src_addr;
   logic [msx_layout_pkg::BYTE_CNT_W-1:0]    byte_count;
   logic                                     fill;       // Generate fill bytes, no DDR3
   logic                                     done;
   logic [msx_layout_pkg::SDRAM_ADDR_W-1:0]  write_addr; // Next SDRAM address

   modport sequencer (
      output start, restart, src_addr, byte_count, fill,
      input  done, write_addr
   );

   modport reader (
      input  start, src_addr, byte_count, fill
   );

   modport writer (
      input  start, restart, byte_count,
      output done, write_addr
   );

endinterface

`default_nettype wire

//--- source/layout_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module layout_sequencer (
   input  wire                          clk,
   input  wire                          reset,
   input  wire                          update_request,
   input  wire msx_layout_pkg::msx_config_t msx_config[msx_layout_pkg::MAX_CONFIG],
   copy_job_if.sequencer                job,
   output logic                         busy,
   output logic                         update_ack,
   output logic                         need_reset,
   output msx_layout_pkg::slot_t        msx_slot[4],
   output msx_layout_pkg::block_t       memory_block[msx_layout_pkg::MAX_MEM_BLOCK]
);

   typedef enum logic [2:0] {
      ST_WAIT,
      ST_CLEAR,
      ST_FILL,
      ST_COPY,
      ST_NEXT
   } state_e;

   state_e                                  state;
   logic [msx_layout_pkg::CONFIG_IDX_W-1:0] config_cnt;
   logic [3:0]                              clear_cnt;   // {slot, subslot}
   msx_layout_pkg::msx_config_t             cfg;
   msx_layout_pkg::slot_typ_e               ent_slot_typ;
   msx_layout_pkg::block_typ_e              ent_block_typ;

   assign cfg  = msx_config[config_cnt];
   assign busy = state != ST_WAIT;

   assign ent_slot_typ = (cfg.typ == msx_layout_pkg::CONFIG_RAM) ?
                         msx_layout_pkg::SLOT_TYP_RAM : msx_layout_pkg::SLOT_TYP_ROM;

   always_comb begin
      case (cfg.typ)
         msx_layout_pkg::CONFIG_RAM: ent_block_typ = msx_layout_pkg::BLOCK_TYP_RAM;
         msx_layout_pkg::CONFIG_FDC: ent_block_typ = msx_layout_pkg::BLOCK_TYP_FDC;
         default:                    ent_block_typ = msx_layout_pkg::BLOCK_TYP_ROM;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state       <= ST_WAIT;
         config_cnt  <= '0;
         clear_cnt   <= '0;
         update_ack  <= 1'b0;
         need_reset  <= 1'b0;
         job.start   <= 1'b0;
         job.restart <= 1'b0;
      end else begin
         update_ack  <= 1'b0;
         need_reset  <= 1'b0;
         job.start   <= 1'b0;
         job.restart <= 1'b0;
         case (state)
            ST_WAIT: begin
               if (update_request) begin
                  state       <= ST_CLEAR;
                  config_cnt  <= '0;
                  clear_cnt   <= '0;
                  update_ack  <= 1'b1;
                  need_reset  <= 1'b1;
                  job.restart <= 1'b1;
               end
            end
            ST_CLEAR: begin
               clear_cnt <= clear_cnt + 4'd1;
               if (&clear_cnt) state <= ST_FILL;
            end
            ST_FILL: begin
               if (cfg.typ == msx_layout_pkg::CONFIG_NONE || cfg.block_count == 8'd0) begin
                  state <= ST_NEXT;                  // Nothing to copy
               end else begin
                  job.start <= 1'b1;
                  state     <= ST_COPY;
               end
            end
            ST_COPY: begin
               if (job.done) state <= ST_NEXT;
            end
            ST_NEXT: begin
               if (config_cnt == msx_layout_pkg::CONFIG_IDX_W'(msx_layout_pkg::MAX_CONFIG - 1)) begin
                  state <= ST_WAIT;
               end else begin
                  config_cnt <= config_cnt + 1'b1;
                  state      <= ST_FILL;
               end
            end
            default: state <= ST_WAIT;
         endcase
      end
   end

   // Slot map, block table and job parameters
   always_ff @(posedge clk) begin
      case (state)
         ST_CLEAR: begin
            msx_slot[clear_cnt[3:2]].typ                    <= msx_layout_pkg::SLOT_TYP_EMPTY;
            msx_slot[clear_cnt[3:2]].sub_typ[clear_cnt[1:0]] <= msx_layout_pkg::SLOT_TYP_EMPTY;
            msx_slot[clear_cnt[3:2]].page[clear_cnt[1:0]]    <= '0;
         end
         ST_FILL: begin
            if (cfg.typ != msx_layout_pkg::CONFIG_NONE) begin
               msx_slot[cfg.slot].typ <= cfg.slot_internal_mapper ?
                                         msx_layout_pkg::SLOT_TYP_MAPPER : ent_slot_typ;
               if (cfg.slot_internal_mapper) msx_slot[cfg.slot].sub_typ[cfg.sub_slot] <= ent_slot_typ;
               for (int k = 0; k < 4; k++) begin
                  // Span clipped at page 3
                  if (cfg.block_count > 8'(k) && int'(cfg.start_block) + k < 4) begin
                     msx_slot[cfg.slot].page[cfg.sub_slot][cfg.start_block + 2'(k)] <=
                        '{block_id: cfg.block_id, offset: 2'(k), init: 1'b1};
                  end
               end
               memory_block[cfg.block_id].typ         <= ent_block_typ;
               memory_block[cfg.block_id].block_count <= cfg.block_count;
               memory_block[cfg.block_id].mem_offset  <= job.write_addr;
               job.src_addr   <= cfg.store_address;
               job.byte_count <= msx_layout_pkg::BYTE_CNT_W'(cfg.block_count) *
                                 msx_layout_pkg::BYTE_CNT_W'(msx_layout_pkg::PAGE_BYTES);
               job.fill       <= cfg.typ == msx_layout_pkg::CONFIG_RAM;
            end
         end
         default: ;
      endcase
   end

endmodule

`default_nettype wire

//--- source/source_reader.sv
`timescale 1ns/1ps
`default_nettype none

module source_reader (
   input  wire                                    clk,
   input  wire                                    reset,
   copy_job_if.reader                             job,
   input  wire                                    ddr3_ready,
   input  wire  [7:0]                             ddr3_dout,
   input  wire                                    full,
   output logic [msx_layout_pkg::DDR3_ADDR_W-1:0] ddr3_addr,
   output logic                                   ddr3_rd,
   output logic                                   push,
   output logic [7:0]                             push_data
);

   logic [msx_layout_pkg::DDR3_ADDR_W-1:0] base;
   logic [msx_layout_pkg::BYTE_CNT_W-1:0]  idx;     // Bytes pushed so far
   logic [msx_layout_pkg::BYTE_CNT_W-1:0]  total;
   logic                                   fill_job;

   // A DDR3 read is only raised with room in the FIFO, so its byte always fits
   assign push      = fill_job ? (idx != total && !full) : (ddr3_rd && ddr3_ready);
   assign push_data = fill_job ? msx_layout_pkg::FILL_BYTE : ddr3_dout;
   assign ddr3_addr = base + msx_layout_pkg::DDR3_ADDR_W'(idx);

   always_ff @(posedge clk) begin
      if (job.start) base <= job.src_addr;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         idx      <= '0;
         total    <= '0;
         fill_job <= 1'b0;
         ddr3_rd  <= 1'b0;
      end else if (job.start) begin
         idx      <= '0;
         total    <= job.byte_count;
         fill_job <= job.fill;
         ddr3_rd  <= 1'b0;
      end else begin
         if (push) idx <= idx + 1'b1;
         if (ddr3_rd && ddr3_ready) begin
            ddr3_rd <= 1'b0;                          // Byte taken this cycle
         end else if (!ddr3_rd && !fill_job && idx != total && !full) begin
            ddr3_rd <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo (
   input  wire        clk,
   input  wire        reset,
   input  wire        push,
   input  wire  [7:0] push_data,
   input  wire        pop,
   output logic [7:0] pop_data,
   output logic       full,
   output logic       empty
);

   // Pointers carry one wrap bit above the index
   logic [7:0]                          mem [msx_layout_pkg::FIFO_DEPTH];
   logic [msx_layout_pkg::FIFO_PTR_W:0] wr_ptr;
   logic [msx_layout_pkg::FIFO_PTR_W:0] rd_ptr;

   always_ff @(posedge clk) begin
      if (push) mem[wr_ptr[msx_layout_pkg::FIFO_PTR_W-1:0]] <= push_data;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push) wr_ptr <= wr_ptr + 1'b1;
         if (pop)  rd_ptr <= rd_ptr + 1'b1;
      end
   end

   assign pop_data = mem[rd_ptr[msx_layout_pkg::FIFO_PTR_W-1:0]];   // Head visible before pop
   assign empty    = wr_ptr == rd_ptr;
   assign full     = (wr_ptr[msx_layout_pkg::FIFO_PTR_W] != rd_ptr[msx_layout_pkg::FIFO_PTR_W])
                  && (wr_ptr[msx_layout_pkg::FIFO_PTR_W-1:0] == rd_ptr[msx_layout_pkg::FIFO_PTR_W-1:0]);

endmodule

`default_nettype wire

//--- source/sdram_writer.sv
`timescale 1ns/1ps
`default_nettype none

module sdram_writer (
   input  wire                                     clk,
   input  wire                                     reset,
   copy_job_if.writer                              job,
   input  wire                                     sdram_ready,
   input  wire  [7:0]                              pop_data,
   input  wire                                     empty,
   output logic                                    pop,
   output logic [msx_layout_pkg::SDRAM_ADDR_W-1:0] sdram_addr,
   output logic [7:0]                              sdram_din,
   output logic                                    sdram_we
);

   logic [msx_layout_pkg::BYTE_CNT_W-1:0] count;   // Writes done in this job
   logic [msx_layout_pkg::BYTE_CNT_W-1:0] total;

   // Each write moves one byte straight from the FIFO head
   assign pop        = !empty && sdram_ready && count != total;
   assign sdram_we   = pop;
   assign sdram_din  = pop_data;
   assign sdram_addr = job.write_addr;

   always_ff @(posedge clk) begin
      if (reset) begin
         job.write_addr <= '0;
         job.done       <= 1'b0;
         count          <= '0;
         total          <= '0;
      end else begin
         job.done <= 1'b0;
         if (job.restart) begin
            job.write_addr <= '0;                      // New walk starts at address 0
         end else if (pop) begin
            job.write_addr <= job.write_addr + 1'b1;
         end
         if (job.start) begin
            count <= '0;
            total <= job.byte_count;
         end else if (pop) begin
            count <= count + 1'b1;
            if (count + msx_layout_pkg::BYTE_CNT_W'(1) == total) job.done <= 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- source/msx_layout_loader.sv
`timescale 1ns/1ps
`default_nettype none

module msx_layout_loader (
   input  wire                                     clk,
   input  wire                                     reset,
   input  wire                                     ddr3_ready,
   input  wire  [7:0]                              ddr3_dout,
   output logic [msx_layout_pkg::DDR3_ADDR_W-1:0]  ddr3_addr,
   output logic                                    ddr3_rd,
   output logic                                    ddr3_request,
   output logic [msx_layout_pkg::SDRAM_ADDR_W-1:0] sdram_addr,
   output logic [7:0]                              sdram_din,
   output logic                                    sdram_we,
   input  wire                                     sdram_ready,
   output logic                                    sdram_request,
   input  wire                                     update_request,
   output logic                                    update_ack,
   output logic                                    need_reset,
   input  wire msx_layout_pkg::msx_config_t msx_config[msx_layout_pkg::MAX_CONFIG],
   output msx_layout_pkg::slot_t                   msx_slot[4],
   output msx_layout_pkg::block_t memory_block[msx_layout_pkg::MAX_MEM_BLOCK]
);

   logic       busy;
   logic       push;
   logic [7:0] push_data;
   logic       full;
   logic       pop;
   logic [7:0] pop_data;
   logic       empty;

   copy_job_if job ();

   assign ddr3_request  = busy;   // Both memories held for the whole walk
   assign sdram_request = busy;

   layout_sequencer u_sequencer (
      .clk            (clk),
      .reset          (reset),
      .update_request (update_request),
      .msx_config     (msx_config),
      .job            (job),
      .busy           (busy),
      .update_ack     (update_ack),
      .need_reset     (need_reset),
      .msx_slot       (msx_slot),
      .memory_block   (memory_block)
   );

   source_reader u_reader (
      .clk        (clk),
      .reset      (reset),
      .job        (job),
      .ddr3_ready (ddr3_ready),
      .ddr3_dout  (ddr3_dout),
      .full       (full),
      .ddr3_addr  (ddr3_addr),
      .ddr3_rd    (ddr3_rd),
      .push       (push),
      .push_data  (push_data)
   );

   byte_fifo u_fifo (
      .clk       (clk),
      .reset     (reset),
      .push      (push),
      .push_data (push_data),
      .pop       (pop),
      .pop_data  (pop_data),
      .full      (full),
      .empty     (empty)
   );

   sdram_writer u_writer (
      .clk         (clk),
      .reset       (reset),
      .job         (job),
      .sdram_ready (sdram_ready),
      .pop_data    (pop_data),
      .empty       (empty),
      .pop         (pop),
      .sdram_addr  (sdram_addr),
      .sdram_din   (sdram_din),
      .sdram_we    (sdram_we)
   );

endmodule

`default_nettype wire

//--- sim/tb_memory_models.sv
`timescale 1ns/1ps
`default_nettype none

module tb_memory_models (
   input  wire                                     clk,
   input  wire                                     reset,
   input  wire                                     heavy,      // Long random stalls
   input  wire                                     mem_clear,
   input  wire  [msx_layout_pkg::DDR3_ADDR_W-1:0]  ddr3_addr,
   input  wire                                     ddr3_rd,
   output logic                                    ddr3_ready = 1'b0,
   output logic [7:0]                              ddr3_dout = 8'h00,
   input  wire  [msx_layout_pkg::SDRAM_ADDR_W-1:0] sdram_addr,
   input  wire  [7:0]                              sdram_din,
   input  wire                                     sdram_we,
   output logic                                    sdram_ready = 1'b0,
   output int                                      write_count = 0
);

   integer     seed = 32'h7474_a398;
   int         delay = 0;                              // Cycles before the next DDR3 answer
   logic [7:0] sdram_mem [4096];

   always @(posedge clk) begin
      if (reset) begin
         ddr3_ready  <= 1'b0;
         sdram_ready <= 1'b0;
         delay       <= 0;
      end else begin
         ddr3_ready <= 1'b0;
         if (ddr3_rd && !ddr3_ready) begin
            if (delay == 0) begin
               ddr3_ready <= 1'b1;
               ddr3_dout  <= ddr3_addr[7:0] ^ 8'h5A;
               delay      <= $unsigned($random(seed)) % (heavy ? 8 : 2);
            end else begin
               delay <= delay - 1;
            end
         end
         sdram_ready <= ($unsigned($random(seed)) % 4) >= (heavy ? 3 : 1);
      end
      if (mem_clear) begin
         write_count <= 0;
         for (int a = 0; a < 4096; a++) sdram_mem[a] <= 8'(a ^ (a >> 4)) ^ 8'hC3;
      end else if (sdram_we) begin
         sdram_mem[sdram_addr[11:0]] <= sdram_din;
         write_count                 <= write_count + 1;
      end
   end

endmodule

`default_nettype wire

//--- sim/msx_layout_assert.sv
`timescale 1ns/1ps
`default_nettype none

module msx_layout_assert (
   input wire clk,
   input wire reset,
   input wire sdram_we,
   input wire sdram_ready,
   input wire ddr3_rd,
   input wire ddr3_ready,
   input wire push,
   input wire full
);

   we_with_ready: assert property (@(posedge clk) disable iff (reset) sdram_we |-> sdram_ready)
      else $error("SDRAM write issued while sdram_ready was low");

   rd_held: assert property (@(posedge clk) disable iff (reset)
                             ddr3_rd && !ddr3_ready |=> ddr3_rd)
      else $error("DDR3 read dropped before ddr3_ready was seen");

   no_push_when_full: assert property (@(posedge clk) disable iff (reset) push |-> !full)
      else $error("FIFO push issued while the FIFO was full");

endmodule

`default_nettype wire

//--- sim/tb_msx_layout_loader.sv
`timescale 1ns/1ps
`default_nettype none

module tb_msx_layout_loader;

   localparam int NUM_RUNS = 4;
   localparam int TIMEOUT  = 20000;                    // Cycles per layout walk

   logic                                    clk = 1'b0;
   logic                                    reset;
   logic                                    ddr3_ready;
   logic [7:0]                              ddr3_dout;
   logic [msx_layout_pkg::DDR3_ADDR_W-1:0]  ddr3_addr;
   logic                                    ddr3_rd;
   logic                                    ddr3_request;
   logic [msx_layout_pkg::SDRAM_ADDR_W-1:0] sdram_addr;
   logic [7:0]                              sdram_din;
   logic                                    sdram_we;
   logic                                    sdram_ready;
   logic                                    sdram_request;
   logic                                    update_request;
   logic                                    update_ack;
   logic                                    need_reset;
   logic                                    heavy;
   logic                                    mem_clear;
   int                                      write_count;
   msx_layout_pkg::msx_config_t             msx_config[msx_layout_pkg::MAX_CONFIG];
   msx_layout_pkg::slot_t                   msx_slot[4];
   msx_layout_pkg::block_t                  memory_block[msx_layout_pkg::MAX_MEM_BLOCK];

   msx_layout_pkg::msx_config_t scen_tab[3][msx_layout_pkg::MAX_CONFIG];
   int                          run_scen[NUM_RUNS]  = '{0, 1, 2, 1};
   bit                          run_heavy[NUM_RUNS] = '{0, 0, 0, 1};  // Rerun under stalls

   msx_layout_pkg::slot_t  exp_slot[4];
   msx_layout_pkg::block_t exp_block[msx_layout_pkg::MAX_MEM_BLOCK];
   bit                     exp_used[msx_layout_pkg::MAX_MEM_BLOCK];
   logic [7:0]             exp_bytes[$];

   msx_layout_loader uut (.*);
   tb_memory_models models (.*);

   bind source_reader msx_layout_assert reader_checks (
      .clk(clk), .reset(reset), .sdram_we(1'b0), .sdram_ready(1'b1),
      .ddr3_rd(ddr3_rd), .ddr3_ready(ddr3_ready), .push(push), .full(full));
   bind sdram_writer msx_layout_assert writer_checks (
      .clk(clk), .reset(reset), .sdram_we(sdram_we), .sdram_ready(sdram_ready),
      .ddr3_rd(1'b0), .ddr3_ready(1'b0), .push(1'b0), .full(1'b0));

   always #50 clk = ~clk;

   task automatic compare_value(input string name, input logic [127:0] expected,
                                input logic [127:0] actual);
      if (actual !== expected) begin
         $display("Mismatch %s expected %h actual %h", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   function automatic msx_layout_pkg::msx_config_t make_cfg(
      msx_layout_pkg::config_typ_e typ, int slot, int sub, int first, int id, int count,
      bit mapper, int addr);
      msx_layout_pkg::msx_config_t c;
      c.typ                  = typ;
      c.slot                 = 2'(slot);
      c.sub_slot             = 2'(sub);
      c.start_block          = 2'(first);
      c.block_id             = msx_layout_pkg::BLOCK_ID_W'(id);
      c.block_count          = 8'(count);
      c.slot_internal_mapper = mapper;
      c.store_address        = msx_layout_pkg::DDR3_ADDR_W'(addr);
      return c;
   endfunction

   // Slot map, block table and SDRAM image that one scenario should leave behind
   task automatic build_expected(input int s);
      msx_layout_pkg::msx_config_t c;
      msx_layout_pkg::slot_typ_e   st;
      msx_layout_pkg::block_typ_e  bt;
      int                          off;
      int                          p;
      off = 0;
      exp_bytes.delete();
      foreach (exp_used[b]) exp_used[b] = 1'b0;
      foreach (exp_slot[i]) exp_slot[i] = '0;
      for (int i = 0; i < msx_layout_pkg::MAX_CONFIG; i++) begin
         c = scen_tab[s][i];
         if (c.typ != msx_layout_pkg::CONFIG_NONE) begin
            st = (c.typ == msx_layout_pkg::CONFIG_RAM) ? msx_layout_pkg::SLOT_TYP_RAM
                                                       : msx_layout_pkg::SLOT_TYP_ROM;
            bt = (c.typ == msx_layout_pkg::CONFIG_RAM) ? msx_layout_pkg::BLOCK_TYP_RAM
               : (c.typ == msx_layout_pkg::CONFIG_FDC) ? msx_layout_pkg::BLOCK_TYP_FDC
                                                       : msx_layout_pkg::BLOCK_TYP_ROM;
            exp_slot[c.slot].typ = c.slot_internal_mapper ? msx_layout_pkg::SLOT_TYP_MAPPER : st;
            if (c.slot_internal_mapper) exp_slot[c.slot].sub_typ[c.sub_slot] = st;
            for (int k = 0; k < int'(c.block_count); k++) begin
               p = int'(c.start_block) + k;
               if (p < 4) begin
                  exp_slot[c.slot].page[c.sub_slot][p].block_id = c.block_id;
                  exp_slot[c.slot].page[c.sub_slot][p].offset   = 2'(k);
                  exp_slot[c.slot].page[c.sub_slot][p].init     = 1'b1;
               end
            end
            exp_block[c.block_id].typ         = bt;
            exp_block[c.block_id].block_count = c.block_count;
            exp_block[c.block_id].mem_offset  = msx_layout_pkg::SDRAM_ADDR_W'(off);
            exp_used[c.block_id]              = 1'b1;
            for (int j = 0; j < int'(c.block_count) * msx_layout_pkg::PAGE_BYTES; j++) begin
               exp_bytes.push_back((c.typ == msx_layout_pkg::CONFIG_RAM) ?
                                   msx_layout_pkg::FILL_BYTE : 8'(c.store_address + j) ^ 8'h5A);
            end
            off += int'(c.block_count) * msx_layout_pkg::PAGE_BYTES;
         end
      end
   endtask

   task automatic run_scenario(input int r);
      int    s;
      int    cycles;
      int    ack_cycles;
      int    nr_cycles;
      string tag;
      s   = run_scen[r];
      tag = $sformatf("run %0d", r);
      build_expected(s);
      @(posedge clk);
      foreach (msx_config[i]) msx_config[i] <= scen_tab[s][i];
      heavy     <= run_heavy[r];
      mem_clear <= 1'b1;
      @(posedge clk);
      mem_clear      <= 1'b0;
      update_request <= 1'b1;
      @(posedge clk);
      update_request <= 1'b0;
      @(negedge clk);
      compare_value({tag, " update_ack"}, 1, update_ack);
      compare_value({tag, " need_reset"}, 1, need_reset);
      compare_value({tag, " ddr3_request"}, 1, ddr3_request);
      compare_value({tag, " sdram_request"}, 1, sdram_request);
      ack_cycles = 1;
      nr_cycles  = 1;
      cycles     = 0;
      while (ddr3_request) begin
         @(negedge clk);
         ack_cycles += int'(update_ack);
         nr_cycles  += int'(need_reset);
         cycles++;
         if (cycles > TIMEOUT) begin
            $display("Timeout: the layout walk of %s did not end", tag);
            $display("TEST FAILED");
            $fatal(1, "layout walk timed out");
         end
      end
      compare_value({tag, " update_ack cycles"}, 1, ack_cycles);
      compare_value({tag, " need_reset cycles"}, 1, nr_cycles);
      foreach (exp_slot[i]) begin
         compare_value($sformatf("%s msx_slot[%0d]", tag, i), exp_slot[i], msx_slot[i]);
      end
      foreach (exp_used[b]) begin
         if (exp_used[b]) begin
            compare_value($sformatf("%s memory_block[%0d]", tag, b), exp_block[b],
                          memory_block[b]);
         end
      end
      foreach (exp_bytes[j]) begin
         compare_value($sformatf("%s sdram[%0d]", tag, j), exp_bytes[j], models.sdram_mem[j]);
      end
      compare_value({tag, " write count"}, exp_bytes.size(), write_count);
   endtask

   initial begin
      reset          = 1'b1;
      update_request = 1'b0;
      heavy          = 1'b0;
      mem_clear      = 1'b0;
      foreach (msx_config[i]) msx_config[i] = '0;
      foreach (scen_tab[s, i]) scen_tab[s][i] = '0;   // CONFIG_NONE everywhere
      scen_tab[0][0] = make_cfg(msx_layout_pkg::CONFIG_RAM,  3, 0, 0, 0, 4, 1, 'h0);
      scen_tab[0][1] = make_cfg(msx_layout_pkg::CONFIG_BIOS, 0, 0, 0, 1, 2, 0, 'h100);
      scen_tab[0][2] = make_cfg(msx_layout_pkg::CONFIG_FDC,  3, 2, 1, 2, 1, 1, 'h2F0);
      scen_tab[1][0] = make_cfg(msx_layout_pkg::CONFIG_BIOS, 0, 0, 2, 3, 5, 0, 'h1234567);
      scen_tab[1][3] = make_cfg(msx_layout_pkg::CONFIG_RAM,  1, 1, 0, 4, 3, 1, 'h0);
      scen_tab[1][5] = make_cfg(msx_layout_pkg::CONFIG_FDC,  2, 0, 3, 5, 2, 0, 'h7FFFF0);
      scen_tab[2][0] = make_cfg(msx_layout_pkg::CONFIG_RAM,  2, 3, 1, 6, 2, 0, 'h0);
      scen_tab[2][1] = make_cfg(msx_layout_pkg::CONFIG_RAM,  0, 0, 0, 7, 0, 0, 'h0);
      scen_tab[2][7] = make_cfg(msx_layout_pkg::CONFIG_BIOS, 2, 3, 3, 8, 1, 0, 'h40);
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      compare_value("reset update_ack", 0, update_ack);
      compare_value("reset need_reset", 0, need_reset);
      compare_value("reset ddr3_rd", 0, ddr3_rd);
      compare_value("reset sdram_we", 0, sdram_we);
      compare_value("reset ddr3_request", 0, ddr3_request);
      compare_value("reset sdram_request", 0, sdram_request);
      for (int r = 0; r < NUM_RUNS; r++) run_scenario(r);
      $display("TEST OK");
      $finish;
   end

endmodule

`default_nettype wire

//--- sources.f
source/msx_layout_pkg.sv
source/copy_job_if.sv
source/layout_sequencer.sv
source/source_reader.sv
source/byte_fifo.sv
source/sdram_writer.sv
source/msx_layout_loader.sv
sim/tb_memory_models.sv
sim/msx_layout_assert.sv
sim/tb_msx_layout_loader.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing --assert -Wno-fatal --top-module tb_msx_layout_loader \
   -f sources.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -q "^TEST OK$" || exit 1
